// ==== verilog.f ====
hw/pipePkg.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/hazardUnit.sv
hw/execUnit.sv
hw/pipeCore.sv
tests/wbMemModel.sv
tests/pipeCore_properties.sv
tests/pipeCoreTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module pipeCoreTb \
    -f verilog.f --Mdir obj_dir -o pipeCoreSim &&
./obj_dir/pipeCoreSim ||
{ echo "build or simulation failed" >&2; exit 1; }

// ==== tests/pipeCoreTb.sv ====
`timescale 1ns/1ps

module pipeCoreTb;

    localparam pipePkg::word_t ResetPc   = 32'h0000_0100;
    localparam int             WaitLimit = 50;

    typedef struct packed {
        pipePkg::word_t    instr;
        logic              retires;  // row produces a register write
        pipePkg::regAddr_t regNum;
        pipePkg::word_t    data;
    } progRow_t;

    logic            clk;
    logic            arstN;
    pipePkg::word_t  instrAddr;
    pipePkg::word_t  instrWord;
    pipePkg::wbM2s_t wbM;
    pipePkg::wbS2m_t wbS;
    pipePkg::dbgWb_t dbg;
    progRow_t        prog [$];

    pipeCore #(.resetPc(ResetPc)) pipeCore_inst (
        .clk         (clk),
        .arstN_i     (arstN),
        .instrAddr_o (instrAddr),
        .instr_i     (instrWord),
        .wbM_o       (wbM),
        .wbS_i       (wbS),
        .dbg_o       (dbg)
    );

    wbMemModel #(.romBase(ResetPc)) wbMemModel_inst (
        .clk         (clk),
        .arstN_i     (arstN),
        .instrAddr_i (instrAddr),
        .instr_o     (instrWord),
        .wbM_i       (wbM),
        .wbS_o       (wbS)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic pipePkg::word_t rTypeInstr(input logic [5:0] funct,
            input pipePkg::regAddr_t rd, input pipePkg::regAddr_t rs,
            input pipePkg::regAddr_t rt);
        return {pipePkg::OpcodeRtype, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic pipePkg::word_t iTypeInstr(input logic [5:0] opcode,
            input pipePkg::regAddr_t rt, input pipePkg::regAddr_t rs, input logic [15:0] imm);
        return {opcode, rs, rt, imm};
    endfunction

    task automatic addRow(input pipePkg::word_t instr, input logic retires,
            input pipePkg::regAddr_t regNum, input pipePkg::word_t data);
        prog.push_back('{instr: instr, retires: retires, regNum: regNum, data: data});
    endtask

    task automatic buildProgram();
        addRow(iTypeInstr(pipePkg::OpcodeAddiu, 5'd1, 5'd0, 16'd5), 1'b1, 5'd1, 32'd5);
        addRow(iTypeInstr(pipePkg::OpcodeAddiu, 5'd2, 5'd0, 16'hFFFD), 1'b1, 5'd2, 32'hFFFF_FFFD);
        addRow(rTypeInstr(pipePkg::FunctAddu, 5'd3, 5'd1, 5'd2), 1'b1, 5'd3, 32'd2);
        addRow(rTypeInstr(pipePkg::FunctSubu, 5'd4, 5'd3, 5'd1), 1'b1, 5'd4, 32'hFFFF_FFFD);
        addRow(rTypeInstr(pipePkg::FunctSlt, 5'd5, 5'd4, 5'd1), 1'b1, 5'd5, 32'd1); // -3 < 5
        addRow(rTypeInstr(pipePkg::FunctSlt, 5'd6, 5'd1, 5'd4), 1'b1, 5'd6, 32'd0);
        addRow(rTypeInstr(pipePkg::FunctAnd, 5'd7, 5'd2, 5'd1), 1'b1, 5'd7, 32'd5);
        addRow(rTypeInstr(pipePkg::FunctOr, 5'd8, 5'd2, 5'd1), 1'b1, 5'd8, 32'hFFFF_FFFD);
        addRow(iTypeInstr(pipePkg::OpcodeAddiu, 5'd0, 5'd1, 16'd7), 1'b0, 5'd0, 32'd0);
        addRow(rTypeInstr(pipePkg::FunctAddu, 5'd9, 5'd0, 5'd1), 1'b1, 5'd9, 32'd5);
        addRow(iTypeInstr(pipePkg::OpcodeAddiu, 5'd10, 5'd0, 16'h0040), 1'b1, 5'd10, 32'h40);
        addRow(iTypeInstr(pipePkg::OpcodeSw, 5'd8, 5'd10, 16'd4), 1'b0, 5'd0, 32'd0);
        addRow(iTypeInstr(pipePkg::OpcodeAddiu, 5'd11, 5'd0, 16'h1234), 1'b1, 5'd11, 32'h1234);
        addRow(iTypeInstr(pipePkg::OpcodeLw, 5'd12, 5'd10, 16'd4), 1'b1, 5'd12, 32'hFFFF_FFFD);
        addRow(rTypeInstr(pipePkg::FunctAddu, 5'd13, 5'd12, 5'd1), 1'b1, 5'd13, 32'd2);
        addRow(iTypeInstr(pipePkg::OpcodeBeq, 5'd9, 5'd1, 16'd2), 1'b0, 5'd0, 32'd0);
        addRow(iTypeInstr(pipePkg::OpcodeAddiu, 5'd14, 5'd0, 16'd99), 1'b0, 5'd0, 32'd0);
        addRow(iTypeInstr(pipePkg::OpcodeAddiu, 5'd15, 5'd0, 16'd77), 1'b0, 5'd0, 32'd0);
        addRow(iTypeInstr(pipePkg::OpcodeAddiu, 5'd16, 5'd1, 16'd1), 1'b1, 5'd16, 32'd6);
        addRow(iTypeInstr(pipePkg::OpcodeBnq, 5'd9, 5'd1, 16'd2), 1'b0, 5'd0, 32'd0);
        addRow(iTypeInstr(pipePkg::OpcodeAddiu, 5'd17, 5'd16, 16'd10), 1'b1, 5'd17, 32'd16);
        addRow(rTypeInstr(pipePkg::FunctSlt, 5'd18, 5'd2, 5'd0), 1'b1, 5'd18, 32'd1);
    endtask

    // table first, nops in the rest of the rom
    task automatic loadProgram();
        for (int i = 0; i < 64; i++) begin
            wbMemModel_inst.writeRom(6'(i), (i < prog.size()) ? prog[i].instr : '0);
        end
    endtask

    function automatic int findFirstMemRow();
        for (int i = 0; i < prog.size(); i++) begin
            if (prog[i].instr[31:26] == pipePkg::OpcodeLw ||
                prog[i].instr[31:26] == pipePkg::OpcodeSw) begin
                return i;
            end
        end
        return prog.size();
    endfunction

    task automatic checkBit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, name, got, expected);
            $display("TEST FAILED");
            $fatal(1, "single-bit output mismatch");
        end
    endtask

    task automatic checkReg(input string name, input pipePkg::regAddr_t got,
            input pipePkg::regAddr_t expected);
        if (got !== expected) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
            $display("TEST FAILED");
            $fatal(1, "register number mismatch");
        end
    endtask

    task automatic checkWord(input string name, input pipePkg::word_t got,
            input pipePkg::word_t expected);
        if (got !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
            $display("TEST FAILED");
            $fatal(1, "data word mismatch");
        end
    endtask

    // busAllowed low means no memory instruction can have reached M yet
    task automatic waitWriteback(input int row, input logic busAllowed);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (!busAllowed) begin
                checkBit("wbM_o.cyc", wbM.cyc, 1'b0);
                checkBit("wbM_o.stb", wbM.stb, 1'b0);
            end
            if (cycles > WaitLimit && !dbg.valid) begin
                $display("no writeback arrived for table row %0d within %0d cycles",
                         row, WaitLimit);
                $display("TEST FAILED");
                $fatal(1, "writeback timeout");
            end
        end while (!dbg.valid);
    endtask

    initial begin
        int firstMemRow;
        void'($urandom(17993));
        arstN = 1'b0;
        buildProgram();
        loadProgram();
        firstMemRow = findFirstMemRow();
        repeat (2) begin
            @(posedge clk);
            #2;
            checkBit("wbM_o.cyc", wbM.cyc, 1'b0);
            checkBit("wbM_o.stb", wbM.stb, 1'b0);
            checkBit("dbg_o.valid", dbg.valid, 1'b0);
        end
        arstN = 1'b1;
        checkWord("instrAddr_o", instrAddr, ResetPc);
        for (int r = 0; r < prog.size(); r++) begin
            if (prog[r].retires) begin
                waitWriteback(r, r + 1 >= firstMemRow);
                checkReg("dbg_o.regNum", dbg.regNum, prog[r].regNum);
                checkWord("dbg_o.data", dbg.data, prog[r].data);
                checkWord("dbg_o.pc", dbg.pc, ResetPc + 32'(r * 4));
            end
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== tests/pipeCore_properties.sv ====
`timescale 1ns/1ps

module pipeCore_properties (
    input logic            clk,
    input logic            arstN_i,
    input pipePkg::wbM2s_t wbMaster_i,
    input pipePkg::wbS2m_t wbSlave_i,
    input pipePkg::dbgWb_t dbg_i
);

    stbNeedsCyc: assert property (@(posedge clk) disable iff (!arstN_i)
        wbMaster_i.stb |-> wbMaster_i.cyc)
        else $error("wishbone stb raised without cyc");

    // an open access keeps its request unchanged until the slave acks
    requestHeld: assert property (@(posedge clk) disable iff (!arstN_i)
        (wbMaster_i.stb && !wbSlave_i.ack) |=>
            (wbMaster_i.stb && $stable(wbMaster_i.adr) && $stable(wbMaster_i.we)
             && $stable(wbMaster_i.dat)))
        else $error("wishbone request changed or dropped before ack");

    noZeroWriteback: assert property (@(posedge clk) disable iff (!arstN_i)
        dbg_i.valid |-> dbg_i.regNum != '0)
        else $error("debug port reported a write to register 0");

endmodule

bind pipeCore pipeCore_properties pipeCore_properties_inst (
    .clk        (clk),
    .arstN_i    (arstN_i),
    .wbMaster_i (wbM_o),
    .wbSlave_i  (wbS_i),
    .dbg_i      (dbg_o)
);

// ==== tests/wbMemModel.sv ====
`timescale 1ns/1ps

module wbMemModel #(
    parameter pipePkg::word_t romBase = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            arstN_i,
    input  pipePkg::word_t  instrAddr_i,
    output pipePkg::word_t  instr_o,
    input  pipePkg::wbM2s_t wbM_i,
    output pipePkg::wbS2m_t wbS_o
);

    pipePkg::word_t rom [0:63];
    pipePkg::word_t ram [0:63];
    pipePkg::word_t romOffset;
    pipePkg::word_t rdData;
    logic           ack;
    logic [1:0]     waitCnt;    // cycles left before ack

    // fill word carries its own byte address
    initial begin
        for (int i = 0; i < 64; i++) begin
            ram[i] = {16'hDA7A, 8'h00, i[5:0], 2'b00};
        end
    end

    task automatic writeRom(input logic [5:0] idx, input pipePkg::word_t word);
        rom[idx] = word;
    endtask

    assign romOffset = instrAddr_i - romBase;
    assign instr_o   = (romOffset[31:8] != '0) ? '0 : rom[romOffset[7:2]]; // nop outside rom

    always @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            ack     <= 1'b0;
            rdData  <= '0;
            waitCnt <= '0;
        end else if (ack) begin
            ack     <= 1'b0;
            waitCnt <= 2'($urandom_range(2, 0)); // next access acks in 1 to 3 cycles
        end else if (wbM_i.cyc && wbM_i.stb) begin
            if (waitCnt == '0) begin
                ack    <= 1'b1;
                rdData <= ram[wbM_i.adr[7:2]];
                if (wbM_i.we) begin
                    ram[wbM_i.adr[7:2]] <= wbM_i.dat;
                end
            end else begin
                waitCnt <= waitCnt - 2'd1;
            end
        end
    end

    assign wbS_o = '{dat: rdData, ack: ack};

endmodule

// ==== hw/pipeCore.sv ====
`timescale 1ns/1ps

module pipeCore #(
    parameter pipePkg::word_t resetPc = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            arstN_i,
    output pipePkg::word_t  instrAddr_o,
    input  pipePkg::word_t  instr_i,
    output pipePkg::wbM2s_t wbM_o,
    input  pipePkg::wbS2m_t wbS_i,
    output pipePkg::dbgWb_t dbg_o
);

    typedef struct packed {
        pipePkg::word_t pc;
        pipePkg::word_t instr;
    } fdReg_t;

    typedef struct packed {
        pipePkg::word_t    pc;
        pipePkg::decoded_t dec;
        pipePkg::word_t    rsVal;
        pipePkg::word_t    rtVal;
    } deReg_t;

    typedef struct packed {
        pipePkg::word_t    pc;
        pipePkg::ctrl_t    ctrl;
        pipePkg::regAddr_t dest;
        pipePkg::word_t    aluOut;
        pipePkg::word_t    storeData;
    } emReg_t;

    pipePkg::word_t    pcF;
    fdReg_t            fd;
    deReg_t            de;
    emReg_t            em;
    pipePkg::dbgWb_t   mw;       // writeback stage, same layout as the debug record
    logic              mwFresh;  // first cycle of mw in W

    pipePkg::decoded_t decD;
    pipePkg::word_t    rsValD;
    pipePkg::word_t    rtValD;
    pipePkg::fwdSel_e  fwdA;
    pipePkg::fwdSel_e  fwdB;
    logic              stallFd;
    logic              holdAll;
    logic              flushFd;
    pipePkg::word_t    aluOutE;
    pipePkg::word_t    storeDataE;
    logic              branchTakenE;
    pipePkg::word_t    branchTarget;
    logic              memAccessM;
    pipePkg::word_t    resultM;

    assign instrAddr_o = pcF;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            pcF <= resetPc;
        end else if (!holdAll) begin
            if (flushFd) begin
                pcF <= branchTarget;
            end else if (!stallFd) begin
                pcF <= pcF + 32'd4;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            fd <= '0;
        end else if (!holdAll) begin
            if (flushFd) begin
                fd <= '0; // all-zero word decodes as a bubble
            end else if (!stallFd) begin
                fd <= '{pc: pcF, instr: instr_i};
            end
        end
    end

    instrDecoder instrDecoder_inst (
        .instr_i (fd.instr),
        .dec_o   (decD)
    );

    regFile regFile_inst (
        .clk       (clk),
        .arstN_i   (arstN_i),
        .rdAddrA_i (decD.rs),
        .rdAddrB_i (decD.rt),
        .rdDataA_o (rsValD),
        .rdDataB_o (rtValD),
        .wrEn_i    (mw.valid),
        .wrAddr_i  (mw.regNum),
        .wrData_i  (mw.data)
    );

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            de <= '0;
        end else if (!holdAll) begin
            if (flushFd || stallFd) begin
                de <= '0; // bubble into E
            end else begin
                de <= '{pc: fd.pc, dec: decD, rsVal: rsValD, rtVal: rtValD};
            end
        end
    end

    hazardUnit hazardUnit_inst (
        .rsD_i         (decD.rs),
        .rtD_i         (decD.rt),
        .rsE_i         (de.dec.rs),
        .rtE_i         (de.dec.rt),
        .destE_i       (de.dec.dest),
        .destM_i       (em.dest),
        .destW_i       (mw.regNum),
        .memReadE_i    (de.dec.ctrl.memRead),
        .regWriteM_i   (em.ctrl.regWrite),
        .regWriteW_i   (mw.valid),
        .memAccessM_i  (memAccessM),
        .ack_i         (wbS_i.ack),
        .branchTaken_i (branchTakenE),
        .fwdA_o        (fwdA),
        .fwdB_o        (fwdB),
        .stallFd_o     (stallFd),
        .holdAll_o     (holdAll),
        .flushFd_o     (flushFd)
    );

    execUnit execUnit_inst (
        .ctrl_i        (de.dec.ctrl),
        .isBranch_i    (de.dec.isBranch),
        .rsVal_i       (de.rsVal),
        .rtVal_i       (de.rtVal),
        .imm_i         (de.dec.imm),
        .fwdA_i        (fwdA),
        .fwdB_i        (fwdB),
        .memResult_i   (em.aluOut),
        .wbResult_i    (mw.data),
        .aluOut_o      (aluOutE),
        .storeData_o   (storeDataE),
        .branchTaken_o (branchTakenE)
    );

    assign branchTarget = de.pc + 32'd4 + {de.dec.imm[29:0], 2'b00}; // pc+4 + imm*4

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            em <= '0;
        end else if (!holdAll) begin
            em <= '{pc: de.pc, ctrl: de.dec.ctrl, dest: de.dec.dest,
                    aluOut: aluOutE, storeData: storeDataE};
        end
    end

    // E/M is frozen until ack, so the bus fields stay stable by construction
    assign memAccessM = em.ctrl.memRead | em.ctrl.memWrite;

    always_comb begin
        wbM_o.cyc = memAccessM;
        wbM_o.stb = memAccessM;
        wbM_o.we  = em.ctrl.memWrite;
        wbM_o.adr = em.aluOut;
        wbM_o.dat = em.storeData;
    end

    assign resultM = em.ctrl.memRead ? wbS_i.dat : em.aluOut;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            mw      <= '0;
            mwFresh <= 1'b0;
        end else if (!holdAll) begin
            mw      <= '{valid: em.ctrl.regWrite, pc: em.pc, regNum: em.dest, data: resultM};
            mwFresh <= 1'b1;
        end else begin
            mwFresh <= 1'b0; // already reported, W is just waiting
        end
    end

    assign dbg_o = '{valid: mw.valid & mwFresh, pc: mw.pc, regNum: mw.regNum, data: mw.data};

endmodule

// ==== hw/execUnit.sv ====
`timescale 1ns/1ps

module execUnit (
    input  pipePkg::ctrl_t   ctrl_i,
    input  logic             isBranch_i,
    input  pipePkg::word_t   rsVal_i,
    input  pipePkg::word_t   rtVal_i,
    input  pipePkg::word_t   imm_i,
    input  pipePkg::fwdSel_e fwdA_i,
    input  pipePkg::fwdSel_e fwdB_i,
    input  pipePkg::word_t   memResult_i,
    input  pipePkg::word_t   wbResult_i,
    output pipePkg::word_t   aluOut_o,
    output pipePkg::word_t   storeData_o,
    output logic             branchTaken_o
);

    pipePkg::word_t opA;
    pipePkg::word_t rtFwd;  // forwarded rt, also the store data
    pipePkg::word_t opB;

    function automatic pipePkg::word_t pickOperand(
        input pipePkg::fwdSel_e sel,
        input pipePkg::word_t   regVal,
        input pipePkg::word_t   memVal,
        input pipePkg::word_t   wbVal
    );
        case (sel)
            pipePkg::fromMem: return memVal;
            pipePkg::fromWb:  return wbVal;
            default:          return regVal;
        endcase
    endfunction

    assign opA         = pickOperand(fwdA_i, rsVal_i, memResult_i, wbResult_i);
    assign rtFwd       = pickOperand(fwdB_i, rtVal_i, memResult_i, wbResult_i);
    assign opB         = ctrl_i.aluSrcImm ? imm_i : rtFwd;
    assign storeData_o = rtFwd;

    always_comb begin
        case (ctrl_i.aluOp)
            pipePkg::aluAdd: aluOut_o = opA + opB;
            pipePkg::aluSub: aluOut_o = opA - opB;
            pipePkg::aluAnd: aluOut_o = opA & opB;
            pipePkg::aluOr:  aluOut_o = opA | opB;
            pipePkg::aluSlt: aluOut_o = {31'b0, $signed(opA) < $signed(opB)};
            default:         aluOut_o = '0;
        endcase
    end

    // beq/bne compare the forwarded register values, not the alu output
    assign branchTaken_o = isBranch_i && ((opA == rtFwd) ^ ctrl_i.branchNe);

endmodule

// ==== hw/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
    input  pipePkg::regAddr_t rsD_i,
    input  pipePkg::regAddr_t rtD_i,
    input  pipePkg::regAddr_t rsE_i,
    input  pipePkg::regAddr_t rtE_i,
    input  pipePkg::regAddr_t destE_i,
    input  pipePkg::regAddr_t destM_i,
    input  pipePkg::regAddr_t destW_i,
    input  logic              memReadE_i,
    input  logic              regWriteM_i,
    input  logic              regWriteW_i,
    input  logic              memAccessM_i,
    input  logic              ack_i,
    input  logic              branchTaken_i,
    output pipePkg::fwdSel_e  fwdA_o,
    output pipePkg::fwdSel_e  fwdB_o,
    output logic              stallFd_o,
    output logic              holdAll_o,
    output logic              flushFd_o
);

    logic loadUse;

    // the younger producer in M wins over W
    function automatic pipePkg::fwdSel_e pickSource(input pipePkg::regAddr_t src);
        if (src == '0) begin
            return pipePkg::fromRegFile;
        end
        if (regWriteM_i && destM_i == src) begin
            return pipePkg::fromMem;
        end
        if (regWriteW_i && destW_i == src) begin
            return pipePkg::fromWb;
        end
        return pipePkg::fromRegFile;
    endfunction

    always_comb begin
        fwdA_o = pickSource(rsE_i);
        fwdB_o = pickSource(rtE_i);
    end

    // load result only exists after M, so the consumer waits one cycle in D
    assign loadUse = memReadE_i && destE_i != '0 &&
                     (destE_i == rsD_i || destE_i == rtD_i);

    assign stallFd_o = loadUse;
    assign holdAll_o = memAccessM_i && !ack_i;   // wishbone access still open
    assign flushFd_o = branchTaken_i && !holdAll_o;

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic              clk,
    input  logic              arstN_i,
    input  pipePkg::regAddr_t rdAddrA_i,
    input  pipePkg::regAddr_t rdAddrB_i,
    output pipePkg::word_t    rdDataA_o,
    output pipePkg::word_t    rdDataB_o,
    input  logic              wrEn_i,
    input  pipePkg::regAddr_t wrAddr_i,
    input  pipePkg::word_t    wrData_i
);

    pipePkg::word_t regs [1:31]; // no storage behind $zero

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn_i && wrAddr_i != '0) begin
            regs[wrAddr_i] <= wrData_i;
        end
    end

    function automatic pipePkg::word_t readPort(input pipePkg::regAddr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wrEn_i && wrAddr_i == addr) begin
            return wrData_i; // write-through bypass
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdDataA_o = readPort(rdAddrA_i);
        rdDataB_o = readPort(rdAddrB_i);
    end

endmodule

// ==== hw/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
    input  pipePkg::word_t    instr_i,
    output pipePkg::decoded_t dec_o
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];

    always_comb begin
        dec_o          = '0;
        dec_o.rs       = instr_i[25:21];
        dec_o.rt       = instr_i[20:16];
        dec_o.imm      = {{16{instr_i[15]}}, instr_i[15:0]}; // sign extend
        dec_o.ctrl.aluOp = pipePkg::aluAdd;
        case (opcode)
            pipePkg::OpcodeRtype: begin
                dec_o.dest          = instr_i[15:11];
                dec_o.ctrl.regWrite = 1'b1;
                case (funct)
                    pipePkg::FunctAddu: dec_o.ctrl.aluOp = pipePkg::aluAdd;
                    pipePkg::FunctSubu: dec_o.ctrl.aluOp = pipePkg::aluSub;
                    pipePkg::FunctAnd:  dec_o.ctrl.aluOp = pipePkg::aluAnd;
                    pipePkg::FunctOr:   dec_o.ctrl.aluOp = pipePkg::aluOr;
                    pipePkg::FunctSlt:  dec_o.ctrl.aluOp = pipePkg::aluSlt;
                    default:            dec_o = '0; // includes sll nop
                endcase
            end
            pipePkg::OpcodeAddiu: begin
                dec_o.dest           = instr_i[20:16];
                dec_o.ctrl.regWrite  = 1'b1;
                dec_o.ctrl.aluSrcImm = 1'b1;
            end
            pipePkg::OpcodeLw: begin
                dec_o.dest           = instr_i[20:16];
                dec_o.ctrl.regWrite  = 1'b1;
                dec_o.ctrl.memRead   = 1'b1;
                dec_o.ctrl.aluSrcImm = 1'b1; // base + offset
            end
            pipePkg::OpcodeSw: begin
                dec_o.ctrl.memWrite  = 1'b1;
                dec_o.ctrl.aluSrcImm = 1'b1;
            end
            pipePkg::OpcodeBeq: begin
                dec_o.isBranch   = 1'b1;
                dec_o.ctrl.aluOp = pipePkg::aluSub;
            end
            pipePkg::OpcodeBnq: begin
                dec_o.isBranch      = 1'b1;
                dec_o.ctrl.aluOp    = pipePkg::aluSub;
                dec_o.ctrl.branchNe = 1'b1;
            end
            default: dec_o = '0; // unknown opcode becomes a bubble
        endcase
        // writes to $zero are dropped here so nothing downstream sees them
        if (dec_o.dest == '0) begin
            dec_o.ctrl.regWrite = 1'b0;
        end
    end

endmodule

// ==== hw/pipePkg.sv ====
package pipePkg;

    typedef logic [31:0] word_t;    // data word or byte address
    typedef logic [4:0]  regAddr_t; // GPR number

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOp_e;

    // where an execute operand comes from
    typedef enum logic [1:0] {
        fromRegFile,
        fromMem,
        fromWb
    } fwdSel_e;

    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   aluSrcImm;  // operand b is the immediate
        aluOp_e aluOp;
        logic   branchNe;   // bne rather than beq
    } ctrl_t;

    typedef struct packed {
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t dest;
        word_t    imm;
        ctrl_t    ctrl;
        logic     isBranch;
    } decoded_t;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        word_t adr;
        word_t dat;
    } wbM2s_t;

    typedef struct packed {
        word_t dat;
        logic  ack;
    } wbS2m_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        regAddr_t regNum;
        word_t    data;
    } dbgWb_t;

    localparam logic [5:0] OpcodeRtype = 6'h00;
    localparam logic [5:0] OpcodeAddiu = 6'h09;
    localparam logic [5:0] OpcodeLw    = 6'h23;
    localparam logic [5:0] OpcodeSw    = 6'h2b;
    localparam logic [5:0] OpcodeBeq   = 6'h04;
    localparam logic [5:0] OpcodeBnq   = 6'h05;

    localparam logic [5:0] FunctAddu = 6'h21;
    localparam logic [5:0] FunctSubu = 6'h23;
    localparam logic [5:0] FunctAnd  = 6'h24;
    localparam logic [5:0] FunctOr   = 6'h25;
    localparam logic [5:0] FunctSlt  = 6'h2a;

endpackage
